//--- files.f
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_exec_stage.sv
rv_pipe_ctrl.sv
rv_core_top.sv
rv_core_sva.sv
tb_rv_core.sv

//--- Makefile
# Verilator build and run for the pipeline slice testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rv_core.sv
// Testbench for the three-stage integer pipeline slice.
// Random OP and OP-IMM words with a reference model, forwarding chains,
// back-pressure, illegal words and first-word latency.
`timescale 1ns/100ps
module tb_rv_core import rv_pkg::*;;

    localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000;
    localparam int DRAIN_LIMIT = 2000;            // Cycles allowed per drain

    logic            g_clk;
    logic            i_rst;
    logic            i_instr_valid;
    logic [XLEN-1:0] i_instr;
    logic            o_instr_ready;
    logic            o_ret_valid;
    ret_t            o_ret;
    logic            i_ret_ready;

    int              seed;
    logic [XLEN-1:0] send_q[$];                   // Words still to send
    ret_t            exp_q[$];                    // Expected records in order
    logic [XLEN-1:0] mrf[0:31];                   // Model register file
    logic [XLEN-1:0] mpc;                         // Model PC
    logic            gaps;                        // Random valid gaps and stalls
    int              errors, checks, tests, failed;
    int              cyc, acc_cyc, rx_cyc;        // Latency bookkeeping

    rv_core_top #(.PC_RESET_ADDR(PC_RESET_ADDR)) rv_core_top_i (
        .g_clk(g_clk), .i_rst(i_rst), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_instr_ready(o_instr_ready), .o_ret_valid(o_ret_valid), .o_ret(o_ret),
        .i_ret_ready(i_ret_ready)
    );

    bind rv_core_top rv_core_sva rv_core_sva_i (
        .g_clk(g_clk), .i_rst(i_rst), .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .i_instr_ready(o_instr_ready), .i_ret_valid(o_ret_valid), .i_ret(o_ret),
        .i_ret_ready(i_ret_ready), .i_rd_wen(rd_wen)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;               // 40 ns period
    end

    // ----------------------------------------
    // Reference model and word generators
    // ----------------------------------------
    function automatic ret_t model_exec(input logic [31:0] w);
        ret_t        r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a, b, res;
        logic        ok;
        f3 = w[14:12];
        f7 = w[31:25];
        a  = mrf[w[19:15]];
        b  = (w[6:0] == OPC_OP) ? mrf[w[24:20]] : {{20{w[31]}}, w[31:20]};
        if (w[6:0] == OPC_OP) ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (w[6:0] == OPC_OP_IMM) ok = (f3 == 3'd1) ? f7 == 7'h00 :
                                             (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
        else ok = 1'b0;
        case (f3)
            3'd0: res = (w[6:0] == OPC_OP && f7[5]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = (a >> b[4:0]) |                     // Sign fill for sra
                        ((f7[5] && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        r.pc     = mpc;
        r.instr  = w;
        r.rd     = w[11:7];
        r.result = ok ? res : 32'h0;              // Traps carry no result
        r.rd_wen = ok;
        r.trap   = !ok;
        if (ok && w[11:7] != 5'd0) mrf[w[11:7]] = res;
        mpc = mpc + 32'd4;
        return r;
    endfunction

    function automatic logic [4:0] rand_reg(input logic [4:0] mask);
        logic [31:0] r;
        r = $random(seed);
        return r[4:0] & mask;
    endfunction

    function automatic logic [31:0] alu_word(input logic [4:0] rd, rs1, rs2);
        logic [31:0] r;
        logic [6:0]  f7;
        r  = $random(seed);
        f7 = (r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00;
        if (r[4]) return {f7, rs2, rs1, r[2:0], rd, OPC_OP};                // Reg-reg
        if (r[2:0] == 3'd1 || r[2:0] == 3'd5) return {f7, r[9:5], rs1, r[2:0], rd, OPC_OP_IMM};
        return {r[31:20], rs1, r[2:0], rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] illegal_word(input logic [4:0] rd);
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) return {7'h01, r[14:10], r[19:15], r[22:20], rd, OPC_OP};  // M extension
        return {r[31:12], rd, 7'b0000011};                                 // Load
    endfunction

    // ----------------------------------------
    // Checking, stepping and reset
    // ----------------------------------------
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic step();
        logic acc, rxf;
        ret_t e;
        @(negedge g_clk);                         // Handshakes stable here
        cyc++;
        check_val("o_instr_ready", {31'b0, o_instr_ready},
                  {31'b0, exp_q.size() < 2 || i_ret_ready});  // Stuck only when both full
        acc = i_instr_valid && o_instr_ready;
        rxf = o_ret_valid && i_ret_ready;
        if (acc) begin
            if (acc_cyc < 0) acc_cyc = cyc;
            exp_q.push_back(model_exec(i_instr));
            void'(send_q.pop_front());
        end
        if (rxf && rx_cyc < 0) rx_cyc = cyc;
        if (rxf && exp_q.size() == 0) begin
            errors++;
            $display("Retire record arrived with no instruction outstanding");
        end else if (rxf) begin
            e = exp_q.pop_front();
            check_val("o_ret.pc", o_ret.pc, e.pc);
            check_val("o_ret.instr", o_ret.instr, e.instr);
            check_val("o_ret.rd", {27'b0, o_ret.rd}, {27'b0, e.rd});
            check_val("o_ret.result", o_ret.result, e.result);
            check_val("o_ret.rd_wen", {31'b0, o_ret.rd_wen}, {31'b0, e.rd_wen});
            check_val("o_ret.trap", {31'b0, o_ret.trap}, {31'b0, e.trap});
        end
        @(posedge g_clk);
        if (!i_instr_valid || acc) begin          // Held words stay put
            i_instr_valid <= send_q.size() != 0 && (!gaps || rand_reg(5'h3) != 5'd0);
            if (send_q.size() != 0) i_instr <= send_q[0];
        end
        i_ret_ready <= !gaps || rand_reg(5'h3) != 5'd0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((send_q.size() != 0 || exp_q.size() != 0) && n < DRAIN_LIMIT) begin
            step();
            n++;
        end
        if (send_q.size() != 0 || exp_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d words unsent and %0d records outstanding",
                     send_q.size(), exp_q.size());
            send_q.delete();
            exp_q.delete();
        end
    endtask

    task automatic apply_reset();
        i_rst         <= 1'b1;
        i_instr_valid <= 1'b0;
        i_ret_ready   <= 1'b1;
        repeat (2) @(posedge g_clk);              // Two reset cycles
        i_rst <= 1'b0;
        for (int r = 0; r < 32; r++) mrf[r] = 32'h0;
        mpc     = PC_RESET_ADDR;
        acc_cyc = -1;
        rx_cyc  = -1;
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %0d %s: PASS", num, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL, %0d errors", num, name, errors - err0);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int          err0;
        logic [4:0]  p1, p2, rd;
        seed = 32'h4686810c;
        i_rst = 1'b1;
        i_instr_valid = 1'b0;
        i_instr = '0;
        i_ret_ready = 1'b1;
        {errors, checks, tests, failed, cyc} = '0;
        gaps = 1'b0;
        apply_reset();

        err0 = errors;
        repeat (80) send_q.push_back(alu_word(rand_reg(5'h7), rand_reg(5'h7), rand_reg(5'h7)));
        drain();
        report_test(1, "random OP and OP-IMM", err0);

        err0 = errors;
        p1 = 5'd1;
        p2 = 5'd2;
        repeat (60) begin
            rd = rand_reg(5'h3);                  // x0 now and then
            send_q.push_back(alu_word(rd, p1, p2));
            p2 = p1;
            p1 = rd;
        end
        drain();
        report_test(2, "dependent chains", err0);

        err0 = errors;
        gaps = 1'b1;
        repeat (120) send_q.push_back(alu_word(rand_reg(5'h7), rand_reg(5'h7), rand_reg(5'h7)));
        drain();
        report_test(3, "back-pressure and gaps", err0);

        err0 = errors;
        repeat (16) begin
            rd = rand_reg(5'h7) | 5'd1;
            send_q.push_back(illegal_word(rd));
            send_q.push_back({12'h000, rd, 3'b000, 5'd9, OPC_OP_IMM});  // Read old rd
        end
        drain();
        gaps = 1'b0;
        report_test(4, "illegal words", err0);

        err0 = errors;
        apply_reset();
        send_q.push_back(alu_word(5'd3, 5'd0, 5'd0));
        drain();
        check_val("retire latency edges", rx_cyc - acc_cyc, 32'd2);
        report_test(5, "first word latency", err0);

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rv_core_sva.sv
// Assertions on the instruction and retire streams of the pipeline
// slice, bound into the top level.
`timescale 1ns/100ps
module rv_core_sva import rv_pkg::*; (
    input logic            g_clk,
    input logic            i_rst,
    input logic            i_instr_valid,
    input logic [XLEN-1:0] i_instr,
    input logic            i_instr_ready,
    input logic            i_ret_valid,
    input ret_t            i_ret,
    input logic            i_ret_ready,
    input logic            i_rd_wen          // Register file write enable
);

    // ----------------------------------------
    // Stream stability under back-pressure
    // ----------------------------------------
    a_instr_hold: assert property (@(posedge g_clk) disable iff (i_rst)
        i_instr_valid && !i_instr_ready |=> i_instr_valid && $stable(i_instr))
        else $error("instruction word dropped or changed before its transfer");

    a_ret_hold: assert property (@(posedge g_clk) disable iff (i_rst)
        i_ret_valid && !i_ret_ready |=> i_ret_valid && $stable(i_ret))
        else $error("retire record dropped or changed before its transfer");

    // Reset empties the retire stage
    a_ret_reset: assert property (@(posedge g_clk) i_rst |=> !i_ret_valid)
        else $error("retire record presented during reset");

    // Trapped records never reach the register file
    a_wr_on_xfer: assert property (@(posedge g_clk) disable iff (i_rst)
        i_rd_wen |-> i_ret_valid && i_ret_ready && !i_ret.trap)
        else $error("register write outside a retire transfer or by a trapped record");

endmodule

//--- rv_core_top.sv
// Top level of the three-stage integer pipeline slice.
// Connects pipeline control, decode, execute/retire and the
// register file between the instruction and retire streams.
`timescale 1ns/100ps
module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000  // PC of first word
) (
    input  logic            g_clk,
    input  logic            i_rst,          // Sync, active high
    input  logic            i_instr_valid,  // Instruction stream
    input  logic [XLEN-1:0] i_instr,
    output logic            o_instr_ready,
    output logic            o_ret_valid,    // Retire stream
    output ret_t            o_ret,
    input  logic            i_ret_ready
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic                  ex_valid;        // Execute stage occupied
    logic                  ex_load;         // Execute register enable
    logic                  ret_load;        // Retire register enable
    logic                  rd_wen;          // Qualified register write
    logic [XLEN-1:0]       pc;              // PC of incoming word
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;        // Raw file read data
    logic [XLEN-1:0]       rs2_data;
    dec_op_t               dec_op;          // Decode to execute
    dec_op_t               ex_op;           // Execute register, for forwarding
    logic [XLEN-1:0]       ex_result;

    rv_pipe_ctrl #(
        .PC_RESET_ADDR (PC_RESET_ADDR)
    ) rv_pipe_ctrl_i (
        .g_clk         (g_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .i_ret_ready   (i_ret_ready),
        .o_ret_valid   (o_ret_valid),
        .o_ex_valid    (ex_valid),
        .o_ex_load     (ex_load),
        .o_ret_load    (ret_load),
        .o_pc          (pc),
        .i_ret_wen     (o_ret.rd_wen),
        .o_rd_wen      (rd_wen)
    );

    rv_decode rv_decode_i (
        .i_instr     (i_instr),             // Same word, read as union
        .i_pc        (pc),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_ex_valid  (ex_valid),
        .i_ex_op     (ex_op),
        .i_ex_result (ex_result),
        .i_ret_valid (o_ret_valid),
        .i_ret       (o_ret),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .o_op        (dec_op)
    );

    rv_exec_stage rv_exec_stage_i (
        .g_clk       (g_clk),
        .i_rst       (i_rst),
        .i_ex_load   (ex_load),
        .i_ret_load  (ret_load),
        .i_op        (dec_op),
        .o_ex_op     (ex_op),
        .o_ex_result (ex_result),
        .o_ret       (o_ret)
    );

    rv_regfile rv_regfile_i (
        .g_clk      (g_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_rd_wen   (rd_wen),
        .i_rd_addr  (o_ret.rd),
        .i_rd_wdata (o_ret.result)
    );

endmodule

//--- rv_pipe_ctrl.sv
// Pipeline control for the execute and retire stages.
// Tracks stage occupancy, derives load enables and input ready under
// retire back-pressure, counts the PC and qualifies register writes.
`timescale 1ns/100ps
module rv_pipe_ctrl import rv_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000  // PC of first word
) (
    input  logic            g_clk,
    input  logic            i_rst,          // Sync, active high
    input  logic            i_instr_valid,  // Instruction stream valid
    output logic            o_instr_ready,  // Instruction stream ready
    input  logic            i_ret_ready,    // Retire stream ready
    output logic            o_ret_valid,    // Retire stream valid
    output logic            o_ex_valid,     // Execute stage occupied
    output logic            o_ex_load,      // Load execute register
    output logic            o_ret_load,     // Load retire register
    output logic [XLEN-1:0] o_pc,           // PC of word at the input
    input  logic            i_ret_wen,      // Retire record writes rd
    output logic            o_rd_wen        // Register file write enable
);

    logic            ex_valid_q;            // Execute stage full
    logic            ret_valid_q;           // Retire stage full
    logic            ret_xfer;              // Record leaves this cycle
    logic [XLEN-1:0] pc_q;

    // ----------------------------------------
    // Handshakes and load enables
    // ----------------------------------------
    assign ret_xfer      = ret_valid_q && i_ret_ready;
    assign o_ret_load    = ex_valid_q && (!ret_valid_q || i_ret_ready);
    assign o_instr_ready = !ex_valid_q || o_ret_load;   // Low only when stuck
    assign o_ex_load     = i_instr_valid && o_instr_ready;

    // ----------------------------------------
    // Stage valid bits
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            ex_valid_q  <= 1'b0;
            ret_valid_q <= 1'b0;
        end else begin
            if (o_ex_load) begin
                ex_valid_q <= 1'b1;             // New word replaces leaving one
            end else if (o_ret_load) begin
                ex_valid_q <= 1'b0;             // Drained into retire
            end
            if (o_ret_load) begin
                ret_valid_q <= 1'b1;
            end else if (ret_xfer) begin
                ret_valid_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Program counter, one word per accept
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            pc_q <= PC_RESET_ADDR;
        end else if (o_ex_load) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign o_pc        = pc_q;
    assign o_ex_valid  = ex_valid_q;
    assign o_ret_valid = ret_valid_q;
    assign o_rd_wen    = ret_xfer && i_ret_wen;   // Commit on transfer only

endmodule

//--- rv_exec_stage.sv
// Execute stage of the pipeline slice.
// Holds the execute register, computes the ALU result and captures
// the retire record that is presented on the retire stream.
`timescale 1ns/100ps
module rv_exec_stage import rv_pkg::*; (
    input  logic            g_clk,
    input  logic            i_rst,          // Sync, active high
    input  logic            i_ex_load,      // Capture decoded operation
    input  logic            i_ret_load,     // Capture retire record
    input  dec_op_t         i_op,           // From decode
    output dec_op_t         o_ex_op,        // Execute register contents
    output logic [XLEN-1:0] o_ex_result,    // For forwarding and retire
    output ret_t            o_ret           // Retire register contents
);

    dec_op_t         ex_q;                  // Execute register
    ret_t            ret_q;                 // Retire register
    logic [XLEN-1:0] alu_res;               // Raw ALU output
    logic [4:0]      shamt;                 // Shift amount
    logic            lt_s;                  // Signed less-than
    logic            lt_u;                  // Unsigned less-than

    // ----------------------------------------
    // Execute register
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            ex_q <= '0;
        end else if (i_ex_load) begin
            ex_q <= i_op;
        end
    end

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    assign shamt = ex_q.opb[4:0];
    assign lt_s  = $signed(ex_q.opa) < $signed(ex_q.opb);
    assign lt_u  = ex_q.opa < ex_q.opb;

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD:  alu_res = ex_q.opa + ex_q.opb;
            ALU_SUB:  alu_res = ex_q.opa - ex_q.opb;
            ALU_SLL:  alu_res = ex_q.opa << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = ex_q.opa ^ ex_q.opb;
            ALU_SRL:  alu_res = ex_q.opa >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(ex_q.opa) >>> shamt);
            ALU_OR:   alu_res = ex_q.opa | ex_q.opb;
            ALU_AND:  alu_res = ex_q.opa & ex_q.opb;
            default:  alu_res = '0;
        endcase
    end

    // Trapped instructions report a zero result
    assign o_ex_result = ex_q.illegal ? '0 : alu_res;

    // ----------------------------------------
    // Retire register
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            ret_q <= '0;
        end else if (i_ret_load) begin
            ret_q.pc     <= ex_q.pc;
            ret_q.instr  <= ex_q.instr;
            ret_q.rd     <= ex_q.rd;
            ret_q.result <= o_ex_result;
            ret_q.rd_wen <= ex_q.rd_wen;
            ret_q.trap   <= ex_q.illegal;   // Illegal word becomes trap
        end
    end

    assign o_ex_op = ex_q;
    assign o_ret   = ret_q;

endmodule

//--- rv_decode.sv
// Instruction decode and operand gather.
// Maps OP and OP-IMM words to an ALU code, builds operand B and
// forwards sources from the execute and retire stages.
`timescale 1ns/100ps
module rv_decode import rv_pkg::*; (
    input  instr_u                i_instr,      // Word being decoded
    input  logic [XLEN-1:0]       i_pc,         // PC of that word
    input  logic [XLEN-1:0]       i_rs1_data,   // Register file read data
    input  logic [XLEN-1:0]       i_rs2_data,
    input  logic                  i_ex_valid,   // Execute stage occupied
    input  dec_op_t               i_ex_op,      // Execute stage operation
    input  logic [XLEN-1:0]       i_ex_result,  // Execute stage ALU result
    input  logic                  i_ret_valid,  // Retire stage occupied
    input  ret_t                  i_ret,        // Retire stage record
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    output dec_op_t               o_op          // Decoded operation
);

    logic            is_op;                     // Register-register group
    logic            is_imm;                    // Register-immediate group
    logic            is_shift;                  // sll / srl / sra encodings
    logic            alt;                       // funct7 = 0100000
    logic            f7_ok;                     // Upper bits legal for funct3
    logic            illegal;                   // Unsupported encoding
    logic [2:0]      funct3;
    logic [6:0]      funct7;                    // Also imm12[11:5]
    logic [XLEN-1:0] rs1_val;                   // Forwarded sources
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm_val;                   // Operand B for OP-IMM

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    assign funct3   = i_instr.r_fmt.funct3;
    assign funct7   = i_instr.r_fmt.funct7;
    assign is_op    = i_instr.r_fmt.opcode == OPC_OP;
    assign is_imm   = i_instr.i_fmt.opcode == OPC_OP_IMM;
    assign is_shift = funct3 == 3'b001 || funct3 == 3'b101;
    assign alt      = funct7 == 7'b0100000;

    // OP-IMM only constrains the upper bits for shifts
    assign f7_ok = (is_imm && !is_shift) || funct7 == 7'b0000000 ||
                   (alt && (funct3 == 3'b101 || (is_op && funct3 == 3'b000)));

    always_comb begin
        case (funct3)
            3'b000:  o_op.alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  o_op.alu_op = ALU_SLL;
            3'b010:  o_op.alu_op = ALU_SLT;
            3'b011:  o_op.alu_op = ALU_SLTU;
            3'b100:  o_op.alu_op = ALU_XOR;
            3'b101:  o_op.alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  o_op.alu_op = ALU_OR;
            default: o_op.alu_op = ALU_AND;
        endcase
    end

    // ----------------------------------------
    // Operand gather by forwarding priority
    // ----------------------------------------
    assign o_rs1_addr = i_instr.r_fmt.rs1;
    assign o_rs2_addr = i_instr.r_fmt.rs2;      // Ignored for OP-IMM

    assign rs1_val = (i_ex_valid && i_ex_op.rd_wen && i_ex_op.rd != '0 &&
                      i_ex_op.rd == o_rs1_addr)             ? i_ex_result :
                     (i_ret_valid && i_ret.rd_wen && i_ret.rd != '0 &&
                      i_ret.rd == o_rs1_addr)               ? i_ret.result : i_rs1_data;
    assign rs2_val = (i_ex_valid && i_ex_op.rd_wen && i_ex_op.rd != '0 &&
                      i_ex_op.rd == o_rs2_addr)             ? i_ex_result :
                     (i_ret_valid && i_ret.rd_wen && i_ret.rd != '0 &&
                      i_ret.rd == o_rs2_addr)               ? i_ret.result : i_rs2_data;

    // Shift immediates keep only shamt
    assign imm_val = is_shift ? {{(XLEN-5){1'b0}}, i_instr.i_fmt.imm12[4:0]} :
                     {{(XLEN-12){i_instr.i_fmt.imm12[11]}}, i_instr.i_fmt.imm12};

    assign illegal      = !((is_op || is_imm) && f7_ok);
    assign o_op.opa     = rs1_val;
    assign o_op.opb     = is_imm ? imm_val : rs2_val;
    assign o_op.rd      = i_instr.r_fmt.rd;
    assign o_op.illegal = illegal;
    assign o_op.rd_wen  = !illegal;              // Traps write nothing
    assign o_op.instr   = i_instr;
    assign o_op.pc      = i_pc;

endmodule

//--- rv_regfile.sv
// General purpose register file.
// Two combinational read ports, one write port, x0 reads as zero.
`timescale 1ns/100ps
module rv_regfile import rv_pkg::*; (
    input  logic                  g_clk,
    input  logic                  i_rst,        // Clears x1..x31
    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data,
    input  logic                  i_rd_wen,     // Retire transfer write
    input  logic [REG_ADDR_W-1:0] i_rd_addr,
    input  logic [XLEN-1:0]       i_rd_wdata
);

    localparam int NREG = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NREG-1];           // No storage for x0

    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            for (int r = 1; r < NREG; r++) begin
                regs[r] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_wdata;      // Writes to x0 dropped
        end
    end

    // Old value seen during a write, decode forwards around it
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- rv_pkg.sv
// Shared definitions for the three-stage integer pipeline slice.
// Holds widths, ALU operation codes, instruction field layouts and
// the records passed between decode, execute and retire.
package rv_pkg;

    localparam int XLEN       = 32;            // Data path width
    localparam int REG_ADDR_W = 5;             // Register address width
    localparam int ALU_OP_W   = 4;             // ALU operation code width

    // ----------------------------------------
    // ALU operation codes
    // ----------------------------------------
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;  // Signed compare
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;  // Unsigned compare
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;  // Arithmetic shift
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate

    // ----------------------------------------
    // Instruction word layouts
    // ----------------------------------------
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;         // Upper 7 bits overlay funct7
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // One word, read as either format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // ----------------------------------------
    // Stage records
    // ----------------------------------------
    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;        // Operation to perform
        logic [XLEN-1:0]       opa;           // Operand A, forwarded rs1
        logic [XLEN-1:0]       opb;           // Operand B, rs2 or immediate
        logic [REG_ADDR_W-1:0] rd;            // Destination register
        logic                  rd_wen;        // Destination write enable
        logic                  illegal;       // Unsupported encoding
        logic [XLEN-1:0]       instr;         // Raw instruction word
        logic [XLEN-1:0]       pc;            // Program counter
    } dec_op_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;            // Program counter
        logic [XLEN-1:0]       instr;         // Raw instruction word
        logic [REG_ADDR_W-1:0] rd;            // Destination register
        logic [XLEN-1:0]       result;        // Write data
        logic                  rd_wen;        // Destination write enable
        logic                  trap;          // Illegal instruction trap
    } ret_t;

endpackage
